// ==== bench/system86MainCtrlTb.sv ====
`timescale 1ns/100ps

module system86MainCtrlTb;

	import system86Pkg::*;

	logic clk6M;
	logic reset;
	logic [addrWidth-1:0] addr;
	logic [dataWidth-1:0] writeData;
	logic memWrite;
	logic vblank;
	logic clk0;
	logic spriteSelect;
	logic video0Select;
	logic video1Select;
	logic eepromSelect;
	logic romSelect;
	logic [latchDepth-1:0][dataWidth-1:0] layer0Regs;
	logic [latchDepth-1:0][dataWidth-1:0] layer1Regs;
	logic [dataWidth-1:0] romBank0;
	logic [dataWidth-1:0] romBank1;
	logic mainReset;
	logic mainIrq;
	logic q;
	logic eClock;

	// Expected latch contents
	logic [latchDepth-1:0][dataWidth-1:0] model0;
	logic [latchDepth-1:0][dataWidth-1:0] model1;

	logic [31:0] lfsrState;
	int errorCount;
	int passCount;
	int failCount;
	int cycleCount;
	int cycleLimit;
	int testIndex;
	int errorsBefore;

	// One entry per pattern line
	byte opList[$];
	logic [31:0] argA[$];
	logic [31:0] argB[$];
	logic [31:0] argC[$];

	system86MainCtrl dut0 (
		.clk6M(clk6M),
		.reset(reset),
		.addr(addr),
		.writeData(writeData),
		.memWrite(memWrite),
		.vblank(vblank),
		.clk0(clk0),
		.spriteSelect(spriteSelect),
		.video0Select(video0Select),
		.video1Select(video1Select),
		.eepromSelect(eepromSelect),
		.romSelect(romSelect),
		.layer0Regs(layer0Regs),
		.layer1Regs(layer1Regs),
		.romBank0(romBank0),
		.romBank1(romBank1),
		.mainReset(mainReset),
		.mainIrq(mainIrq),
		.q(q),
		.eClock(eClock)
	);

	initial begin
		clk6M = 1'b0;
		forever #4 clk6M = ~clk6M;
	end

	// Run limit stays zero until the patterns are loaded
	always @(posedge clk6M) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout after %0d clock cycles, the tests did not finish", cycleCount);
			$display("Verification failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	// One step per bit taken
	function automatic logic [7:0] randomBits(input int count);
		logic [7:0] value;
		int i;
		value = '0;
		for (i = 0; i < count; i++) begin
			if (lfsrState[0]) begin
				lfsrState = (lfsrState >> 1) ^ 32'h80200003;
			end else begin
				lfsrState = lfsrState >> 1;
			end
			value = {value[6:0], lfsrState[0]};
		end
		return value;
	endfunction

	task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0d ns: %s is %0h, expected %0h",
				$time, what, actual, expected);
			errorCount++;
		end
	endtask

	// Model of the D000h and D800h groups
	// Index comes from address bits 2..0
	task automatic modelWrite(input logic [15:0] a, input logic [7:0] d);
		if (a[15:11] == 5'b11010) begin
			model0[a[2:0]] = d;
		end else if (a[15:11] == 5'b11011) begin
			model1[a[2:0]] = d;
		end
	endtask

	task automatic checkLatches();
		checkValue(layer0Regs, model0, "layer0Regs");
		checkValue(layer1Regs, model1, "layer1Regs");
		// Bank byte is entry 3
		checkValue(romBank0, model0[3], "romBank0");
		checkValue(romBank1, model1[3], "romBank1");
	endtask

	// One write cycle
	// Registers are updated by the following falling edge
	task automatic busWrite(input logic [15:0] a, input logic [7:0] d);
		@(negedge clk6M);
		addr = a;
		writeData = d;
		memWrite = 1'b1;
		@(negedge clk6M);
		memWrite = 1'b0;
		modelWrite(a, d);
	endtask

	task automatic vblankPulse();
		@(negedge clk6M);
		vblank = 1'b1;
		repeat (4) @(negedge clk6M);
		vblank = 1'b0;
		repeat (3) @(negedge clk6M);
	endtask

	task automatic reportTest(input int number, input byte op, input logic ok);
		if (ok) begin
			passCount++;
		end else begin
			failCount++;
		end
		$display("test %0d (%c) %s", number, op, ok ? "ok" : "FAILED");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Pattern operations
	//////////////////////////////////////////////////////////////////////

	task automatic runDecode(input logic [31:0] a, input logic [31:0] wr,
			input logic [31:0] expSel);
		logic [7:0] data;
		data = randomBits(8);
		@(negedge clk6M);
		addr = a[15:0];
		writeData = data;
		memWrite = wr[0];
		// Selects are combinational and settle well before the next edge
		#2;
		checkValue({spriteSelect, video0Select, video1Select, eepromSelect, romSelect},
			expSel[4:0], "select vector");
		@(negedge clk6M);
		memWrite = 1'b0;
		if (wr[0]) begin
			modelWrite(a[15:0], data);
		end
	endtask

	// Given byte first and then random bytes at random indices of the group
	task automatic runWrite(input logic [31:0] a, input logic [31:0] d,
			input logic [31:0] extra);
		logic [7:0] indexBits;
		logic [7:0] data;
		int k;
		busWrite(a[15:0], d[7:0]);
		checkLatches();
		for (k = 0; k < extra; k++) begin
			indexBits = randomBits(3);
			data = randomBits(8);
			repeat (randomBits(2)) @(negedge clk6M);
			busWrite({a[15:3], indexBits[2:0]}, data);
			checkLatches();
		end
	endtask

	// Acknowledge alone or in the cycle of a vblank edge
	task automatic runAck(input logic [31:0] withVblank, input logic [31:0] expIrq);
		if (withVblank[0]) begin
			@(negedge clk6M);
			vblank = 1'b1;
			busWrite(16'h8800, randomBits(8));
			repeat (2) @(negedge clk6M);
			vblank = 1'b0;
			repeat (3) @(negedge clk6M);
		end else begin
			busWrite(16'h8800, randomBits(8));
		end
		checkValue(mainIrq, expIrq[0], "mainIrq after acknowledge");
	endtask

	task automatic runPhase(input logic [31:0] cycles);
		logic [3:0] qSeq;
		logic [3:0] eSeq;
		int k;
		// Bit k is the value k edges after clk0 rises
		qSeq = 4'b0110;
		eSeq = 4'b1100;
		@(negedge clk6M);
		clk0 = 1'b1;
		for (k = 0; k <= cycles; k++) begin
			if (k > 0) begin
				@(negedge clk6M);
			end
			checkValue(q, qSeq[k % 4], "q");
			checkValue(eClock, eSeq[k % 4], "eClock");
		end
		clk0 = 1'b0;
		@(negedge clk6M);
		checkValue(q, 0, "q with clk0 low");
		checkValue(eClock, 0, "eClock with clk0 low");
	endtask

	task automatic loadPatterns();
		int fd;
		int code;
		int longest;
		byte op;
		string lineBuf;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen("bench/system86Patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file bench/system86Patterns.txt");
			errorCount++;
		end else begin
			longest = 8;
			code = $fscanf(fd, " %c", op);
			while (code == 1) begin
				code = $fgets(lineBuf, fd);
				// Lines starting with # hold the column notes
				if (op != "#") begin
					a = '0;
					b = '0;
					c = '0;
					code = $sscanf(lineBuf, "%h %h %h", a, b, c);
					opList.push_back(op);
					argA.push_back(a);
					argB.push_back(b);
					argC.push_back(c);
					if (op == "V" && 8 * a > longest) begin
						longest = 8 * a;
					end
				end
				code = $fscanf(fd, " %c", op);
			end
			$fclose(fd);
			// Longest operation is a run of 8 cycle vblank pulses
			cycleLimit = opList.size() * longest + 100;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		cycleCount = 0;
		cycleLimit = 0;
		lfsrState = 32'h6d43;
		model0 = '0;
		model1 = '0;
		reset = 1'b1;
		addr = '0;
		writeData = '0;
		memWrite = 1'b0;
		vblank = 1'b0;
		clk0 = 1'b0;
		loadPatterns();
		repeat (3) @(negedge clk6M);
		reset = 1'b0;
		@(negedge clk6M);
		// Everything idle straight out of reset
		checkLatches();
		checkValue(mainReset, 0, "mainReset after reset");
		checkValue(mainIrq, 0, "mainIrq after reset");
		checkValue(q, 0, "q after reset");
		checkValue(eClock, 0, "eClock after reset");
		reportTest(0, "R", errorCount == 0);
		for (testIndex = 0; testIndex < opList.size(); testIndex++) begin
			errorsBefore = errorCount;
			case (opList[testIndex])
				"D": runDecode(argA[testIndex], argB[testIndex], argC[testIndex]);
				"W": runWrite(argA[testIndex], argB[testIndex], argC[testIndex]);
				"V": begin
					repeat (argA[testIndex]) vblankPulse();
					checkValue(mainReset, argB[testIndex][0], "mainReset after vblank");
					checkValue(mainIrq, argC[testIndex][0], "mainIrq after vblank");
				end
				"K": begin
					busWrite(16'h8000, randomBits(8));
					checkValue(mainReset, 0, "mainReset after kick");
				end
				"A": runAck(argA[testIndex], argB[testIndex]);
				"P": runPhase(argA[testIndex]);
				default: begin
					$display("Pattern %0d has an unknown operation", testIndex + 1);
					errorCount++;
				end
			endcase
			reportTest(testIndex + 1, opList[testIndex], errorCount == errorsBefore);
		end
		$display("Tests passed %0d, failed %0d, assertion failures %0d",
			passCount, failCount, dut0.checks0.assertFailures);
		if (failCount == 0 && errorCount == 0 && dut0.checks0.assertFailures == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== bench/system86MainCtrl_assert.sv ====
`timescale 1ns/100ps

// Concurrent checks bound to the main control top level
module system86MainCtrlAssert (
	input logic clk6M,
	input logic reset,
	input logic [system86Pkg::addrWidth-1:0] addr,
	input logic memWrite,
	input logic vblank,
	input logic spriteSelect,
	input logic video0Select,
	input logic video1Select,
	input logic eepromSelect,
	input logic romSelect,
	input logic mainReset,
	input logic mainIrq
);

	import system86Pkg::*;

	// Failure count read by the testbench summary
	int assertFailures;

	logic kickSeen;
	logic [4:0] selects;

	initial assertFailures = 0;

	assign kickSeen = memWrite && (addr[addrWidth-1 -: strobeWidth] == kickCode);
	assign selects = {spriteSelect, video0Select, video1Select, eepromSelect, romSelect};

	// Decoder never enables two chips at once
	selectsExclusive: assert property (@(posedge clk6M) disable iff (reset)
		$onehot0(selects)) else begin
		$error("more than one chip select is high");
		assertFailures++;
	end

	// Vblank sampled high, then the edge cycle, then the request
	irqFromVblank: assert property (@(posedge clk6M) disable iff (reset)
		$rose(mainIrq) |-> $past(vblank, 2) && !$past(vblank, 3)) else begin
		$error("mainIrq rose without a vblank edge");
		assertFailures++;
	end

	// Release only on a kick or on the wrap at a vblank edge
	resetRelease: assert property (@(posedge clk6M) disable iff (reset)
		$fell(mainReset) |-> $past(kickSeen) || ($past(vblank, 2) && !$past(vblank, 3)))
		else begin
		$error("mainReset fell without a kick or a watchdog wrap");
		assertFailures++;
	end

endmodule

bind system86MainCtrl system86MainCtrlAssert checks0 (
	.clk6M(clk6M),
	.reset(reset),
	.addr(addr),
	.memWrite(memWrite),
	.vblank(vblank),
	.spriteSelect(spriteSelect),
	.video0Select(video0Select),
	.video1Select(video1Select),
	.eepromSelect(eepromSelect),
	.romSelect(romSelect),
	.mainReset(mainReset),
	.mainIrq(mainIrq)
);

// ==== bench/system86Patterns.txt ====
# D addr write selects{sprite,video0,video1,eeprom,rom}  W addr data randomWrites
# V pulses mainReset mainIrq  K  A withVblank mainIrq  P cyclesWithClk0High
D 0000 0 10
D 1fff 1 10
D 2000 0 08
D 3fff 1 08
D 4000 0 04
D 5fff 1 04
D 6000 0 02
D 7fff 1 00
D 7fff 0 02
D 8000 0 01
D 8000 1 00
D 8800 1 00
D d000 1 00
D d807 1 00
D ffff 0 01
W d000 5a 3
W d803 c3 3
W d007 ff 2
W 2000 11 0
W d800 00 4
V 1 0 1
A 0 0
V 1 0 1
A 1 1
A 0 0
K
V 7 0 1
K
V 7 0 1
V 1 1 1
V 2 1 1
V 1 0 1
P 12
P 6

// ==== design/cpuPhaseGen.sv ====
`timescale 1ns/100ps

// Main CPU clock phases from the 6 MHz master clock
// clk0 gates the count so the phases restart in step with it
module cpuPhaseGen (
	input logic clk6M,
	input logic reset,
	input logic clk0,
	output logic q,
	output logic eClock
);

	// Quarter period counter
	logic [1:0] phaseCount;
	logic [1:0] phaseNext;

	// Held at zero while clk0 is low
	// otherwise wraps 0 1 2 3
	always_comb begin
		if (clk0) begin
			phaseNext = phaseCount + 2'd1;
		end else begin
			phaseNext = 2'd0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Phase registers
	//////////////////////////////////////////////////////////////////////

	// Outputs load from the next count so they stay aligned
	// with phaseCount and change on the same edge
	always_ff @(posedge clk6M) begin
		if (reset) begin
			phaseCount <= 2'd0;
			q <= 1'b0;
			eClock <= 1'b0;
		end else begin
			phaseCount <= phaseNext;

			// Q leads E by a quarter period, 0 1 1 0
			q <= phaseNext[1] ^ phaseNext[0];

			// E is the counter msb, 0 0 1 1
			eClock <= phaseNext[1];
		end
	end

endmodule

// ==== design/mainBusControl.sv ====
`timescale 1ns/100ps

// Main CPU address decoder
// Pure combinational, no clock
module mainBusControl (
	input logic [system86Pkg::addrWidth-1:0] addr,
	input logic memWrite,
	output logic spriteSelect,
	output logic video0Select,
	output logic video1Select,
	output logic eepromSelect,
	output logic romSelect,
	output logic latch0Write,
	output logic latch1Write,
	output logic watchdogKick,
	output logic intAck
);

	import system86Pkg::*;

	// Upper address fields
	logic [regionWidth-1:0] regionField;
	logic [strobeWidth-1:0] strobeField;

	// Top address bit splits RAM half from ROM half
	logic romHalf;

	// Strobe field matches before qualifying with the write level
	logic kickHit;
	logic intAckHit;
	logic latch0Hit;
	logic latch1Hit;

	assign regionField = addr[addrWidth-1 -: regionWidth];
	assign strobeField = addr[addrWidth-1 -: strobeWidth];
	assign romHalf = addr[addrWidth-1];

	//////////////////////////////////////////////////////////////////////
	// Chip selects
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Sprite RAM 0000h to 1FFFh, read and write
		spriteSelect = (regionField == regionSprite);

		// Video RAM for layers A and B at 2000h
		video0Select = (regionField == regionVideo0);

		// Video RAM for layers C and D at 4000h
		video1Select = (regionField == regionVideo1);

		// Program EEPROM window 6000h to 7FFFh
		// Read only so a write cycle never selects it
		eepromSelect = (regionField == regionEeprom) && !memWrite;

		// Banked program ROM 8000h to FFFFh, also read only
		romSelect = romHalf && !memWrite;
	end

	//////////////////////////////////////////////////////////////////////
	// Write strobes
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		kickHit = (strobeField == kickCode);
		intAckHit = (strobeField == intAckCode);
		latch0Hit = (strobeField == latch0Code);
		latch1Hit = (strobeField == latch1Code);
	end

	always_comb begin
		// 8000h watchdog kick
		watchdogKick = memWrite && kickHit;

		// 8800h vblank interrupt acknowledge
		intAck = memWrite && intAckHit;

		// D000h to D007h, scroll and priority for layers A and B
		// plus ROM bank byte at D003h
		latch0Write = memWrite && latch0Hit;

		// D800h to D807h, same layout for layers C and D
		latch1Write = memWrite && latch1Hit;
	end

endmodule

// ==== design/system86MainCtrl.sv ====
`timescale 1ns/100ps

// Main CPU support logic, all in the clk6M domain
module system86MainCtrl (
	input logic clk6M,
	input logic reset,
	input logic [system86Pkg::addrWidth-1:0] addr,
	input logic [system86Pkg::dataWidth-1:0] writeData,
	input logic memWrite,
	input logic vblank,
	input logic clk0,
	output logic spriteSelect,
	output logic video0Select,
	output logic video1Select,
	output logic eepromSelect,
	output logic romSelect,
	output logic [system86Pkg::latchDepth-1:0][system86Pkg::dataWidth-1:0] layer0Regs,
	output logic [system86Pkg::latchDepth-1:0][system86Pkg::dataWidth-1:0] layer1Regs,
	output logic [system86Pkg::dataWidth-1:0] romBank0,
	output logic [system86Pkg::dataWidth-1:0] romBank1,
	output logic mainReset,
	output logic mainIrq,
	output logic q,
	output logic eClock
);

	import system86Pkg::*;

	// Strobes from the decoder
	logic latch0Write;
	logic latch1Write;
	logic watchdogKick;
	logic intAck;

	//////////////////////////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////////////////////////

	mainBusControl busControl (
		.addr(addr),
		.memWrite(memWrite),
		.spriteSelect(spriteSelect),
		.video0Select(video0Select),
		.video1Select(video1Select),
		.eepromSelect(eepromSelect),
		.romSelect(romSelect),
		.latch0Write(latch0Write),
		.latch1Write(latch1Write),
		.watchdogKick(watchdogKick),
		.intAck(intAck)
	);

	// CPU E and Q
	cpuPhaseGen phaseGen (
		.clk6M(clk6M),
		.reset(reset),
		.clk0(clk0),
		.q(q),
		.eClock(eClock)
	);

	// Watchdog and vblank interrupt
	vblankSupervisor supervisor (
		.clk6M(clk6M),
		.reset(reset),
		.vblank(vblank),
		.watchdogKick(watchdogKick),
		.intAck(intAck),
		.mainReset(mainReset),
		.mainIrq(mainIrq)
	);

	//////////////////////////////////////////////////////////////////////
	// Tile layer latches
	//////////////////////////////////////////////////////////////////////

	// Layers A and B at D000h
	tileLayerLatches #(
		.groupBase({latch0Code, {(addrWidth-strobeWidth){1'b0}}})
	) latchGroup0 (
		.clk6M(clk6M),
		.reset(reset),
		.write(latch0Write),
		.index(addr[indexWidth-1:0]),
		.writeData(writeData),
		.layerRegs(layer0Regs),
		.romBank(romBank0)
	);

	// Layers C and D at D800h
	tileLayerLatches #(
		.groupBase({latch1Code, {(addrWidth-strobeWidth){1'b0}}})
	) latchGroup1 (
		.clk6M(clk6M),
		.reset(reset),
		.write(latch1Write),
		.index(addr[indexWidth-1:0]),
		.writeData(writeData),
		.layerRegs(layer1Regs),
		.romBank(romBank1)
	);

endmodule

// ==== design/system86Pkg.sv ====
// Shared constants for the main CPU support logic

package system86Pkg;

	//////////////////////////////////////////////////////////////////////
	// CPU bus
	//////////////////////////////////////////////////////////////////////

	// 6809 style address and data buses
	localparam int addrWidth = 16;
	localparam int dataWidth = 8;

	// Region field is address bits 15..13
	localparam int regionWidth = 3;

	// 8K regions in the low half of the map
	localparam logic [regionWidth-1:0] regionSprite = 3'b000;
	localparam logic [regionWidth-1:0] regionVideo0 = 3'b001;
	localparam logic [regionWidth-1:0] regionVideo1 = 3'b010;
	localparam logic [regionWidth-1:0] regionEeprom = 3'b011;

	// Strobe field is address bits 15..11, 2K granularity
	localparam int strobeWidth = 5;

	// Write-only locations in the ROM half
	localparam logic [strobeWidth-1:0] kickCode = 5'b10000;
	localparam logic [strobeWidth-1:0] intAckCode = 5'b10001;
	localparam logic [strobeWidth-1:0] latch0Code = 5'b11010;
	localparam logic [strobeWidth-1:0] latch1Code = 5'b11011;

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	// Frame counter, top bit drives the CPU reset
	localparam int watchdogWidth = 4;

	// Count that wraps back to zero
	localparam logic [watchdogWidth-1:0] watchdogLimit = 4'd10;

	//////////////////////////////////////////////////////////////////////
	// Tile layer latches
	//////////////////////////////////////////////////////////////////////

	// Bytes per group, scroll X/Y and priority for two layers
	localparam int latchDepth = 8;

	// Byte select taken from the low address bits
	localparam int indexWidth = $clog2(latchDepth);

	// ROM bank byte sits at offset 3 in each group
	localparam int bankOffset = 3;

endpackage

// ==== design/tileLayerLatches.sv ====
`timescale 1ns/100ps

// CPU written register group for one pair of tile layers
// Bytes 0..2 scroll and priority for the first layer
// Byte 3 ROM bank select, bytes 4..6 the second layer
module tileLayerLatches #(
	// Base address of the group, D000h or D800h
	parameter logic [system86Pkg::addrWidth-1:0] groupBase = '0
) (
	input logic clk6M,
	input logic reset,
	input logic write,
	input logic [system86Pkg::indexWidth-1:0] index,
	input logic [system86Pkg::dataWidth-1:0] writeData,
	output logic [system86Pkg::latchDepth-1:0][system86Pkg::dataWidth-1:0] layerRegs,
	output logic [system86Pkg::dataWidth-1:0] romBank
);

	import system86Pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////////////

	// One byte per write strobe, indexed by the low address bits
	always_ff @(posedge clk6M) begin
		if (reset) begin
			layerRegs <= '0;
		end else if (write) begin
			layerRegs[index] <= writeData;
		end
	end

	// Bank byte goes to the ROM bank logic on its own port
	assign romBank = layerRegs[bankOffset];

endmodule

// ==== design/vblankSupervisor.sv ====
`timescale 1ns/100ps

// Vblank driven watchdog and interrupt request for the main CPU
module vblankSupervisor (
	input logic clk6M,
	input logic reset,
	input logic vblank,
	input logic watchdogKick,
	input logic intAck,
	output logic mainReset,
	output logic mainIrq
);

	import system86Pkg::*;

	// Vblank input stage and previous sample
	logic vblankSync;
	logic vblankPrev;
	logic vblankRise;

	// Frames since the last kick
	logic [watchdogWidth-1:0] watchdogCount;

	//////////////////////////////////////////////////////////////////////
	// Vblank edge
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk6M) begin
		if (reset) begin
			vblankSync <= 1'b0;
			vblankPrev <= 1'b0;
		end else begin
			vblankSync <= vblank;
			vblankPrev <= vblankSync;
		end
	end

	// High for one cycle, the cycle after vblank is first sampled high
	assign vblankRise = vblankSync && !vblankPrev;

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk6M) begin
		if (reset) begin
			watchdogCount <= '0;
		end else if (watchdogKick) begin
			// Kick wins over a coinciding frame
			watchdogCount <= '0;
		end else if (vblankRise) begin
			if (watchdogCount == watchdogLimit) begin
				// Wrap releases the CPU reset
				watchdogCount <= '0;
			end else begin
				watchdogCount <= watchdogCount + 1'b1;
			end
		end
	end

	// Reset held for counts 8 through the limit
	assign mainReset = watchdogCount[watchdogWidth-1];

	//////////////////////////////////////////////////////////////////////
	// Interrupt request
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk6M) begin
		if (reset) begin
			mainIrq <= 1'b0;
		end else if (vblankRise) begin
			// New frame sets the request even during an acknowledge
			mainIrq <= 1'b1;
		end else if (intAck) begin
			mainIrq <= 1'b0;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f system86MainCtrl.f \
	--top-module system86MainCtrlTb -Mdir obj_dir || { echo "build failed"; exit 1; }
result=$(./obj_dir/Vsystem86MainCtrlTb)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -q "Verification passed" && exit 0 || exit 1

// ==== system86MainCtrl.f ====
design/system86Pkg.sv
design/mainBusControl.sv
design/cpuPhaseGen.sv
design/vblankSupervisor.sv
design/tileLayerLatches.sv
design/system86MainCtrl.sv
bench/system86MainCtrl_assert.sv
bench/system86MainCtrlTb.sv
